// ==== Makefile ====
# Verilator flow for the rail power sequencer

TOP_TB  = pwr_seq_tb
OBJ_DIR = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f pwr_seq.f --top-module pwr_seq_top

sim:
	verilator --binary --timing --assert -f pwr_seq.f --top-module $(TOP_TB) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP_TB))"; echo "$$out"; \
	echo "$$out" | grep -q "^All tests passed$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== hdl/pg_input_sync.sv ====
/*
 * Two-flop synchronizers for the power-good vector and system enable.
 * Each power-good bit is synchronized on its own, so bits that change together
 * may land a cycle apart. host_clear pulses once per sysen_s falling edge.
 */
`timescale 1ns/1ps

module pg_input_sync import pwr_seq_pkg::*; (
	input  logic      clk_in,
	input  logic      rst_n,
	input  rail_vec_t pg,
	input  logic      sysen,
	output rail_vec_t pg_s,
	output logic      sysen_s,
	output logic      host_clear
);

	rail_vec_t pg_meta;
	logic      sysen_meta;
	logic      sysen_d;

	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n) begin
			pg_meta    <= '0;
			pg_s       <= '0;
			sysen_meta <= 1'b0;
			sysen_s    <= 1'b0;
			sysen_d    <= 1'b0;
		end else begin
			pg_meta    <= pg;
			pg_s       <= pg_meta;
			sysen_meta <= sysen;
			sysen_s    <= sysen_meta;
			// Extra stage only feeds the edge detector
			sysen_d    <= sysen_s;
		end
	end

	// High for the first cycle in which sysen_s reads low
	assign host_clear = sysen_d & ~sysen_s;

endmodule

// ==== hdl/pwr_seq_defs.svh ====
/*
 * Build limits for the rail power sequencer, all counted in clk_in cycles.
 * SEQ_TIMER_WIDTH must hold the largest of the three limits.
 * Rail 0 gets the longer timeout because an ATX supply is slow to report good.
 */
`ifndef PWR_SEQ_DEFS_SVH
`define PWR_SEQ_DEFS_SVH

// Number of sequenced rails
`define SEQ_RAIL_COUNT 9

// Hold time after a rail's power-good before the next rail starts
`define SEQ_DWELL_CYCLES 16

// Power-good wait for an ordinary rail
`define SEQ_PG_TIMEOUT_CYCLES 64

// Power-good wait for rail 0
`define SEQ_FIRST_TIMEOUT_CYCLES 256

// Enough bits for SEQ_FIRST_TIMEOUT_CYCLES
`define SEQ_TIMER_WIDTH 9

`endif

// ==== hdl/pwr_seq_pkg.sv ====
/*
 * Types shared by the rail power sequencer.
 * Bit 0 of a rail vector is the first rail up and the last one down.
 */
`include "pwr_seq_defs.svh"

package pwr_seq_pkg;

	// One bit per rail
	typedef logic [`SEQ_RAIL_COUNT-1:0] rail_vec_t;

	// Index of the rail being sequenced
	typedef logic [$clog2(`SEQ_RAIL_COUNT)-1:0] rail_idx_t;

	// Sequencer states
	typedef enum logic [2:0] {
		IDLE,
		ENABLE,
		DWELL,
		ON,
		SHUTDOWN,
		FAULT
	} seq_state_t;

	// Host visible status, fault is the OR of the two error bits
	typedef struct packed {
		logic sysen;
		logic sysgood;
		logic wait_err;
		logic operation_err;
		logic fault;
	} seq_status_t;

endpackage

// ==== hdl/pwr_seq_top.sv ====
/*
 * Rail power sequencer top level running directly on clk_in.
 * pg and sysen may be asynchronous, clear_err must be a one-cycle strobe.
 * Mapping rails to board pins is left to the instantiating design.
 */
`timescale 1ns/1ps

module pwr_seq_top import pwr_seq_pkg::*; (
	input  logic        clk_in,
	input  logic        rst_n,
	input  logic        sysen,
	input  rail_vec_t   pg,
	input  logic        clear_err,
	output rail_vec_t   en,
	output logic        sysgood,
	output seq_status_t status,
	output rail_vec_t   fail_detail
);

	rail_vec_t pg_s;
	rail_vec_t rails_up;
	rail_idx_t rail_cur;
	logic      sysen_s;
	logic      host_clear;
	logic      timer_start;
	logic      timer_dwell;
	logic      timer_expired;
	logic      wait_timeout;
	logic      fault;

	pg_input_sync pg_input_sync_inst (
		.clk_in     (clk_in),
		.rst_n      (rst_n),
		.pg         (pg),
		.sysen      (sysen),
		.pg_s       (pg_s),
		.sysen_s    (sysen_s),
		.host_clear (host_clear)
	);

	rail_timer rail_timer_inst (
		.clk_in        (clk_in),
		.rst_n         (rst_n),
		.timer_start   (timer_start),
		.timer_dwell   (timer_dwell),
		.rail_cur      (rail_cur),
		.timer_expired (timer_expired)
	);

	seq_fsm seq_fsm_inst (
		.clk_in        (clk_in),
		.rst_n         (rst_n),
		.pg_s          (pg_s),
		.sysen_s       (sysen_s),
		.fault         (fault),
		.timer_expired (timer_expired),
		.timer_start   (timer_start),
		.timer_dwell   (timer_dwell),
		.rail_cur      (rail_cur),
		.wait_timeout  (wait_timeout),
		.en            (en),
		.rails_up      (rails_up),
		.sysgood       (sysgood)
	);

	// sysgood also feeds the status word
	rail_fault_log rail_fault_log_inst (
		.clk_in       (clk_in),
		.rst_n        (rst_n),
		.pg_s         (pg_s),
		.en           (en),
		.rails_up     (rails_up),
		.sysen_s      (sysen_s),
		.sysgood      (sysgood),
		.wait_timeout (wait_timeout),
		.clear_err    (clear_err),
		.host_clear   (host_clear),
		.fault        (fault),
		.status       (status),
		.fail_detail  (fail_detail)
	);

endmodule

// ==== hdl/rail_fault_log.sv ====
/*
 * Latches wait and operation errors and the per-rail fault detail.
 * fail_detail is en XOR pg_s taken as the first error is seen.
 * clear_err or a sysen falling edge wipes errors and detail together.
 */
`timescale 1ns/1ps

module rail_fault_log import pwr_seq_pkg::*; (
	input  logic        clk_in,
	input  logic        rst_n,
	input  rail_vec_t   pg_s,
	input  rail_vec_t   en,
	input  rail_vec_t   rails_up,
	input  logic        sysen_s,
	input  logic        sysgood,
	input  logic        wait_timeout,
	input  logic        clear_err,
	input  logic        host_clear,
	output logic        fault,
	output seq_status_t status,
	output rail_vec_t   fail_detail
);

	logic wait_err;
	logic operation_err;
	logic op_detect;
	logic clear;

	// A rail that finished its dwell has lost power-good
	assign op_detect = |(rails_up & ~pg_s);
	assign clear     = clear_err | host_clear;

	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n) begin
			wait_err      <= 1'b0;
			operation_err <= 1'b0;
			fail_detail   <= '0;
		end else if (clear) begin
			wait_err      <= 1'b0;
			operation_err <= 1'b0;
			fail_detail   <= '0;
		end else begin
			if (wait_timeout) begin
				wait_err <= 1'b1;
			end
			if (op_detect) begin
				operation_err <= 1'b1;
			end
			// Detail only from the first error, lands with fault
			if (!fault && (wait_timeout || op_detect)) begin
				fail_detail <= en ^ pg_s;
			end
		end
	end

	assign fault = wait_err | operation_err;

	assign status.sysen         = sysen_s;
	assign status.sysgood       = sysgood;
	assign status.wait_err      = wait_err;
	assign status.operation_err = operation_err;
	assign status.fault         = fault;

endmodule

// ==== hdl/rail_timer.sv ====
/*
 * Shared down-counter for the dwell and power-good timeout of the current rail.
 * timer_expired pulses exactly the limit in cycles after timer_start, then the
 * counter idles. A start while running reloads it.
 */
`timescale 1ns/1ps
`include "pwr_seq_defs.svh"

module rail_timer import pwr_seq_pkg::*; (
	input  logic      clk_in,
	input  logic      rst_n,
	input  logic      timer_start,
	input  logic      timer_dwell,
	input  rail_idx_t rail_cur,
	output logic      timer_expired
);

	logic [`SEQ_TIMER_WIDTH-1:0] limit;
	logic [`SEQ_TIMER_WIDTH-1:0] count;
	logic                        running;

	// Limit picked by mode and rail
	always_comb begin
		if (timer_dwell) begin
			limit = `SEQ_TIMER_WIDTH'(`SEQ_DWELL_CYCLES);
		end else if (rail_cur == '0) begin
			limit = `SEQ_TIMER_WIDTH'(`SEQ_FIRST_TIMEOUT_CYCLES);
		end else begin
			limit = `SEQ_TIMER_WIDTH'(`SEQ_PG_TIMEOUT_CYCLES);
		end
	end

	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n) begin
			count         <= '0;
			running       <= 1'b0;
			timer_expired <= 1'b0;
		end else begin
			timer_expired <= 1'b0;
			if (timer_start) begin
				// One cycle is spent here, the pulse lands on count zero
				count   <= limit - 1'b1;
				running <= 1'b1;
			end else if (running) begin
				count <= count - 1'b1;
				if (count == `SEQ_TIMER_WIDTH'(1)) begin
					running       <= 1'b0;
					timer_expired <= 1'b1;
				end
			end
		end
	end

endmodule

// ==== hdl/seq_fsm.sv ====
/*
 * Rail sequencing FSM with one rail in flight at a time.
 * Rails come up in index order and go down in reverse order, and a latched
 * fault drops every enable at once. Shutdown waits on power-good with no timeout.
 */
`timescale 1ns/1ps
`include "pwr_seq_defs.svh"

module seq_fsm import pwr_seq_pkg::*; (
	input  logic      clk_in,
	input  logic      rst_n,
	input  rail_vec_t pg_s,
	input  logic      sysen_s,
	input  logic      fault,
	input  logic      timer_expired,
	output logic      timer_start,
	output logic      timer_dwell,
	output rail_idx_t rail_cur,
	output logic      wait_timeout,
	output rail_vec_t en,
	output rail_vec_t rails_up,
	output logic      sysgood
);

	localparam rail_idx_t last_rail = rail_idx_t'(`SEQ_RAIL_COUNT - 1);

	seq_state_t state;
	rail_idx_t  rail_next;
	rail_idx_t  rail_prev;
	logic       expired;
	logic       go_down;

	// A pulse that meets a fresh start belongs to an older run
	assign expired = timer_expired & ~timer_start;

	assign rail_next = rail_cur + 1'b1;
	assign rail_prev = rail_cur - 1'b1;

	// Power-good missed its window, unless it arrived on the same cycle
	assign wait_timeout = (state == ENABLE) & expired & ~pg_s[rail_cur];

	// Shutdown request from any powered state
	assign go_down = ~sysen_s & ((state == ENABLE) | (state == DWELL) | (state == ON));

	assign sysgood = (state == ON);

	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n) begin
			state       <= IDLE;
			rail_cur    <= '0;
			en          <= '0;
			rails_up    <= '0;
			timer_start <= 1'b0;
			timer_dwell <= 1'b0;
		end else begin
			timer_start <= 1'b0;
			if (fault && state != FAULT) begin
				// Everything off in one step
				state    <= FAULT;
				en       <= '0;
				rails_up <= '0;
			end else if (go_down) begin
				// rail_cur is always the highest rail enabled
				en[rail_cur]       <= 1'b0;
				rails_up[rail_cur] <= 1'b0;
				state              <= SHUTDOWN;
			end else begin
				case (state)
					IDLE: begin
						if (sysen_s) begin
							rail_cur    <= '0;
							en[0]       <= 1'b1;
							timer_start <= 1'b1;
							timer_dwell <= 1'b0;
							state       <= ENABLE;
						end
					end
					ENABLE: begin
						// On expiry the fault log latches and fault moves us on
						if (pg_s[rail_cur]) begin
							timer_start <= 1'b1;
							timer_dwell <= 1'b1;
							state       <= DWELL;
						end
					end
					DWELL: begin
						if (expired) begin
							rails_up[rail_cur] <= 1'b1;
							if (rail_cur == last_rail) begin
								state <= ON;
							end else begin
								rail_cur      <= rail_next;
								en[rail_next] <= 1'b1;
								timer_start   <= 1'b1;
								timer_dwell   <= 1'b0;
								state         <= ENABLE;
							end
						end
					end
					ON: begin
						// Only a fault or sysen low leaves this state
						state <= ON;
					end
					SHUTDOWN: begin
						if (!pg_s[rail_cur]) begin
							if (rail_cur == '0) begin
								state <= IDLE;
							end else begin
								rail_cur            <= rail_prev;
								en[rail_prev]       <= 1'b0;
								rails_up[rail_prev] <= 1'b0;
							end
						end
					end
					FAULT: begin
						en       <= '0;
						rails_up <= '0;
						if (!fault) begin
							state <= IDLE;
						end
					end
					default: begin
						state <= IDLE;
					end
				endcase
			end
		end
	end

endmodule

// ==== pwr_seq.f ====
+incdir+hdl
hdl/pwr_seq_pkg.sv
hdl/pg_input_sync.sv
hdl/rail_timer.sv
hdl/seq_fsm.sv
hdl/rail_fault_log.sv
hdl/pwr_seq_top.sv
testbench/pwr_seq_sva.sv
testbench/pwr_seq_tb.sv

// ==== testbench/pwr_seq_sva.sv ====
/*
 * Assertions on enable ordering and fault shutdown, bound into pwr_seq_top.
 * All checks are off while rst_n is low.
 */
`timescale 1ns/1ps

module pwr_seq_sva import pwr_seq_pkg::*; (
	input logic      clk_in,
	input logic      rst_n,
	input rail_vec_t en,
	input logic      sysgood,
	input logic      fault
);

	// Enables always form a run starting at rail 0
	en_order_a: assert property (
		@(posedge clk_in) disable iff (!rst_n)
		((en >> 1) & ~en) == '0
	) else $error("enable high above a rail that is off, en=%b", en);

	en_sysgood_a: assert property (
		@(posedge clk_in) disable iff (!rst_n)
		sysgood |-> (en == '1)
	) else $error("sysgood high with en=%b", en);

	// One cycle from fault to every rail off
	fault_off_a: assert property (
		@(posedge clk_in) disable iff (!rst_n)
		fault |=> (en == '0)
	) else $error("enables still on after fault, en=%b", en);

endmodule

bind pwr_seq_top pwr_seq_sva pwr_seq_sva_inst (
	.clk_in  (clk_in),
	.rst_n   (rst_n),
	.en      (en),
	.sysgood (sysgood),
	.fault   (fault)
);

// ==== testbench/pwr_seq_tb.sv ====
/*
 * Testbench for pwr_seq_top with a behavioral rail model.
 * A rail reports power-good a random delay after its enable, always within a
 * quarter of its timeout, and drops it pg_fall_cycles after the enable falls.
 * Outputs are read at the rising edge, before that edge's updates land.
 */
`timescale 1ns/1ps
`include "pwr_seq_defs.svh"

module pwr_seq_tb import pwr_seq_pkg::*; ();

	localparam int rail_count     = `SEQ_RAIL_COUNT;
	localparam int pg_fall_cycles = 3;
	// Two sync stages, the edge detector and the latch
	localparam int settle_cycles  = 5;
	// Per rail worst case is its timeout and dwell plus sync and FSM steps
	localparam int power_up_bound = `SEQ_FIRST_TIMEOUT_CYCLES
		+ (rail_count - 1) * `SEQ_PG_TIMEOUT_CYCLES
		+ rail_count * (`SEQ_DWELL_CYCLES + 8);
	localparam int shutdown_bound = rail_count * (pg_fall_cycles + 8);
	localparam int run_limit      = 5 * power_up_bound + 5 * shutdown_bound + 200;
	localparam int wait_sysgood   = 0;
	localparam int wait_fault     = 1;
	localparam int wait_down      = 2;

	logic        clk_in;
	logic        rst_n;
	logic        sysen;
	logic        clear_err;
	rail_vec_t   pg;
	rail_vec_t   en;
	logic        sysgood;
	seq_status_t status;
	rail_vec_t   fail_detail;

	rail_vec_t stuck;
	rail_vec_t dropped;
	rail_vec_t en_q;
	rail_vec_t pg_q;
	int        pg_delay [rail_count];
	int        en_rise [rail_count];
	int        en_fall [rail_count];
	int        pg_rise [rail_count];
	int        cyc;
	string     cur_test;
	int        test_errors;
	int        tests_run;
	int        tests_failed;
	int        problems;

	pwr_seq_top pwr_seq_top_inst (
		.clk_in      (clk_in),
		.rst_n       (rst_n),
		.sysen       (sysen),
		.pg          (pg),
		.clear_err   (clear_err),
		.en          (en),
		.sysgood     (sysgood),
		.status      (status),
		.fail_detail (fail_detail)
	);

	initial begin
		clk_in = 1'b0;
		forever #2 clk_in = ~clk_in;
	end

	// Stuck rails never come up and dropped rails go low at once
	initial begin : rail_model
		int up_cnt [rail_count];
		int down_cnt [rail_count];
		pg = '0;
		forever begin
			@(posedge clk_in);
			for (int i = 0; i < rail_count; i++) begin
				if (dropped[i]) begin
					pg[i] <= 1'b0;
				end else if (en[i]) begin
					down_cnt[i] = 0;
					if (!pg[i] && !stuck[i]) begin
						up_cnt[i] = up_cnt[i] + 1;
						if (up_cnt[i] >= pg_delay[i]) pg[i] <= 1'b1;
					end
				end else begin
					up_cnt[i] = 0;
					if (pg[i]) begin
						down_cnt[i] = down_cnt[i] + 1;
						if (down_cnt[i] >= pg_fall_cycles) pg[i] <= 1'b0;
					end
				end
			end
		end
	end

	// Edge times of enables and power-goods in cycles
	always @(posedge clk_in) begin
		cyc  <= cyc + 1;
		en_q <= rst_n ? en : '0;
		pg_q <= rst_n ? pg : '0;
		for (int i = 0; i < rail_count; i++) begin
			if (en[i] && !en_q[i]) en_rise[i] <= cyc;
			if (!en[i] && en_q[i]) en_fall[i] <= cyc;
			if (pg[i] && !pg_q[i]) pg_rise[i] <= cyc;
		end
	end

	initial begin : watchdog
		while (cyc < run_limit) begin
			@(posedge clk_in);
		end
		$display("Run stopped after %0d cycles because a test never finished", cyc);
		$display("Some tests failed");
		$finish;
	end

	function automatic int pg_timeout(input int idx);
		return (idx == 0) ? `SEQ_FIRST_TIMEOUT_CYCLES : `SEQ_PG_TIMEOUT_CYCLES;
	endfunction

	// Only the failing rail has its enable and power-good apart
	function automatic rail_vec_t expected_detail(input int idx);
		return rail_vec_t'(1) << idx;
	endfunction

	task automatic check(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("ERROR %s %s: expected %0h, actual %0h", cur_test, what, expected, actual);
			test_errors++;
			problems++;
		end
	endtask

	task automatic start_test(input string name);
		cur_test    = name;
		test_errors = 0;
	endtask

	task automatic finish_test();
		tests_run++;
		if (test_errors == 0) begin
			$display("%s: done", cur_test);
		end else begin
			tests_failed++;
			$display("%s: failed with %0d problems", cur_test, test_errors);
		end
	endtask

	task automatic wait_for(input int cond, input int limit, output bit ok);
		int    n;
		string what;
		n  = 0;
		ok = 1'b0;
		while (!ok && n < limit) begin
			@(posedge clk_in);
			n++;
			case (cond)
				wait_sysgood: ok = sysgood;
				wait_fault:   ok = status.fault;
				default:      ok = (en == '0) && (pg == '0);
			endcase
		end
		if (!ok) begin
			case (cond)
				wait_sysgood: what = "sysgood";
				wait_fault:   what = "a latched fault";
				default:      what = "all rails to power down";
			endcase
			$display("%s: timed out after %0d cycles waiting for %s", cur_test, limit, what);
			test_errors++;
			problems++;
		end
	endtask

	task automatic power_down(output bit ok);
		sysen <= 1'b0;
		wait_for(wait_down, shutdown_bound, ok);
		repeat (settle_cycles) @(posedge clk_in);
	endtask

	// Stuck rail whose fault is cleared by the sysen falling edge
	task automatic run_wait_error(input int rail);
		bit ok;
		start_test($sformatf("wait_error_rail%0d", rail));
		stuck[rail] <= 1'b1;
		sysen       <= 1'b1;
		wait_for(wait_fault, power_up_bound, ok);
		if (ok) begin
			check("not flagged before timeout", 32'd1,
				32'((cyc - en_rise[rail]) >= pg_timeout(rail)));
			check("wait_err", 32'd1, 32'(status.wait_err));
			check("operation_err", 32'd0, 32'(status.operation_err));
			check("fail_detail", 32'(expected_detail(rail)), 32'(fail_detail));
			@(posedge clk_in);
			check("en after fault", 32'd0, 32'(en));
		end
		stuck[rail] <= 1'b0;
		power_down(ok);
		check("status after sysen fall", 32'd0, 32'(status));
		check("fail_detail after sysen fall", 32'd0, 32'(fail_detail));
		check("en after sysen fall", 32'd0, 32'(en));
		finish_test();
	endtask

	initial begin : test_sequence
		bit ok;
		int k;
		int j;
		rst_n     = 1'b0;
		sysen     = 1'b0;
		clear_err = 1'b0;
		stuck     = '0;
		dropped   = '0;
		void'($urandom(32'h01958c75));
		for (int i = 0; i < rail_count; i++) begin
			pg_delay[i] = $urandom_range(pg_timeout(i) / 4, 4);
		end
		k = $urandom_range(rail_count - 1, 1);
		j = $urandom_range(rail_count - 1, 0);
		repeat (5) @(posedge clk_in);
		rst_n <= 1'b1;
		@(posedge clk_in);

		start_test("power_up");
		check("en after reset", 32'd0, 32'(en));
		check("status after reset", 32'd0, 32'({sysgood, status, fail_detail}));
		sysen <= 1'b1;
		wait_for(wait_sysgood, power_up_bound, ok);
		for (int i = 1; i < rail_count && ok; i++) begin
			check($sformatf("rail %0d order", i), 32'd1, 32'(en_rise[i] > en_rise[i - 1]));
			check($sformatf("rail %0d dwell", i), 32'd1,
				32'((en_rise[i] - pg_rise[i - 1]) >= `SEQ_DWELL_CYCLES));
		end
		check("en", 32'({rail_count{1'b1}}), 32'(en));
		// sysen and sysgood set with no error bits
		check("status", 32'(5'b11000), 32'(status));
		finish_test();

		start_test("shutdown");
		power_down(ok);
		for (int i = 1; i < rail_count && ok; i++) begin
			check($sformatf("rail %0d falls after rail %0d", i - 1, i), 32'd1,
				32'(en_fall[i - 1] > en_fall[i]));
		end
		check("sysgood", 32'd0, 32'(sysgood));
		check("status", 32'd0, 32'(status));
		finish_test();

		run_wait_error(0);
		run_wait_error(k);

		start_test("operation_error");
		sysen <= 1'b1;
		wait_for(wait_sysgood, power_up_bound, ok);
		dropped[j] <= 1'b1;
		wait_for(wait_fault, shutdown_bound, ok);
		if (ok) begin
			check("operation_err", 32'd1, 32'(status.operation_err));
			check("wait_err", 32'd0, 32'(status.wait_err));
			check("fail_detail", 32'(expected_detail(j)), 32'(fail_detail));
			@(posedge clk_in);
			check("en after fault", 32'd0, 32'(en));
		end
		finish_test();

		// Host clear with sysen still high restarts the sequence
		start_test("clear_restart");
		dropped[j] <= 1'b0;
		wait_for(wait_down, shutdown_bound, ok);
		clear_err <= 1'b1;
		@(posedge clk_in);
		clear_err <= 1'b0;
		@(posedge clk_in);
		check("error bits", 32'd0, 32'({status.wait_err, status.operation_err, status.fault}));
		check("fail_detail", 32'd0, 32'(fail_detail));
		wait_for(wait_sysgood, power_up_bound, ok);
		check("en", 32'({rail_count{1'b1}}), 32'(en));
		power_down(ok);
		check("status after shutdown", 32'd0, 32'(status));
		finish_test();

		$display("Tests run %0d, failing tests %0d, problems %0d", tests_run, tests_failed,
			problems);
		if (tests_failed == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule
